// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = msx_config_tb
FILELIST  = sim.f
PASS_MSG  = Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== sim.f ====
+incdir+verilog
verilog/msx_cart_pkg.sv
verilog/msx_user_pkg.sv
verilog/slot_if.sv
verilog/slot_a_decoder.sv
verilog/slot_b_decoder.sv
verilog/config_combiner.sv
verilog/msx_config.sv
testbench/tb_clock_gen.sv
testbench/msx_config_checker.sv
testbench/msx_config_tb.sv

// ==== testbench/config_input.txt ====
// slot_a slot_b ocm_mode disable_fdc sw11 sw15 cas border exp_a_typ exp_b_typ
// all hex; expected types in cart_typ_t encoding (c = empty, b = megaram)
0 0 0 0 1 0 0 0 0 8
1 1 0 0 0 1 1 0 1 0
2 2 0 0 1 1 0 1 2 1
3 3 0 0 0 0 1 1 3 2
4 4 0 0 1 0 0 0 4 3
4 5 1 0 0 1 1 0 b b
5 5 0 0 1 1 0 1 6 5
6 6 0 0 0 0 1 1 7 9
6 6 1 0 1 0 0 0 7 b
7 7 0 0 0 1 1 0 c a
8 7 1 0 1 1 0 1 c b
9 8 0 0 0 0 1 1 c c
a 9 1 0 1 0 0 0 c c
b 0 0 1 0 1 1 0 c c
4 a 1 0 1 1 0 1 b c
c b 0 0 0 0 1 1 c c
d c 1 1 1 0 0 0 c c
e d 0 0 0 1 1 0 c c
f f 0 0 1 1 0 1 c c
0 e 1 0 0 0 1 1 0 c

// ==== testbench/msx_config_checker.sv ====
`default_nettype none

module msx_config_checker (
    input logic clk,
    input logic reset,
    input logic reload_req,
    input logic reload_ack
);
    timeunit 1ns;
    timeprecision 100ps;

    // **************************************************
    // reload handshake toward the loader
    // **************************************************

    req_held: assert property (@(posedge clk) disable iff (reset)
        reload_req && !reload_ack |=> reload_req)
        else $error("reload_req dropped before reload_ack arrived");

    req_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(reload_req) |-> !$past(reload_ack))
        else $error("reload_req rose while reload_ack was high");

    req_reset: assert property (@(posedge clk) reset |=> !reload_req)
        else $error("reload_req high in the cycle after reset");

endmodule

bind config_combiner msx_config_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .reload_req (reload_req),
    .reload_ack (reload_ack)
);

`default_nettype wire

// ==== testbench/msx_config_tb.sv ====
`default_nettype none
`include "msx_macros.svh"

module msx_config_tb
    import msx_cart_pkg::*;
    import msx_user_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_VEC    = 20;
    localparam int NUM_COLS   = 10;
    localparam int NUM_TESTS  = NUM_VEC + 2;  // plus reset and burst
    localparam int CLK_PERIOD = 40;

    logic                 clk;
    logic                 reset;
    logic [`STATUS_W-1:0] status;
    logic                 disable_fdc;
    logic                 ocm_mode;
    logic                 reload_ack;
    cart_typ_t            cart_a_typ;
    cart_typ_t            cart_b_typ;
    logic                 rom_a_hide;
    logic                 rom_b_hide;
    user_config_t         user_cfg;
    logic                 reload_req;

    logic [3:0]  vec_mem [NUM_VEC*NUM_COLS];
    logic [31:0] lcg_state = 32'h0de43806;
    int          hs_done = 0;  // completed handshakes
    cart_typ_t   loaded_a;     // pair seen by the loader at req
    cart_typ_t   loaded_b;
    cart_typ_t   last_a;
    cart_typ_t   last_b;
    int          errors = 0;
    int          checks = 0;

    tb_clock_gen u_clock (.clk(clk), .reset(reset));

    msx_config dut (
        .clk(clk), .reset(reset), .status(status),
        .disable_fdc(disable_fdc), .ocm_mode(ocm_mode), .reload_ack(reload_ack),
        .cart_a_typ(cart_a_typ), .cart_b_typ(cart_b_typ),
        .rom_a_hide(rom_a_hide), .rom_b_hide(rom_b_hide),
        .user_cfg(user_cfg), .reload_req(reload_req)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [3:0] vec_field(input int v, input int col);
        logic [7:0] idx;
        idx = 8'(v * NUM_COLS + col);
        return vec_mem[idx];
    endfunction

    function automatic user_config_t model_cfg(input int v);
        user_config_t cfg;
        logic [1:0]   b_map;
        case (vec_field(v, 1))
            4'd5:    b_map = 2'd2;  // scc+
            4'd6:    b_map = 2'd1;  // ascii 8k
            4'd7:    b_map = 2'd3;  // ascii 16k
            default: b_map = 2'd0;
        endcase
        cfg.cas_audio_src = cas_audio_src_t'(vec_field(v, 6) != 4'd0);
        cfg.border        = (vec_field(v, 7) != 4'd0);
        cfg.ocm_dip       = {1'b0, vec_field(v, 4) == 4'd0, b_map,
                             vec_field(v, 0) == 4'd4, 2'b00, vec_field(v, 5) != 4'd0};
        return cfg;
    endfunction

    task automatic apply_vector(input int v);
        status                             = '0;
        status[`SLOT_A_LSB +: `SLOT_SEL_W] = vec_field(v, 0);
        status[`SLOT_B_LSB +: `SLOT_SEL_W] = vec_field(v, 1);
        ocm_mode                           = (vec_field(v, 2) != 4'd0);
        disable_fdc                        = (vec_field(v, 3) != 4'd0);
        status[`BIT_OCM_SW11]              = (vec_field(v, 4) != 4'd0);
        status[`BIT_OCM_SW15]              = (vec_field(v, 5) != 4'd0);
        status[`BIT_CAS_SRC]               = (vec_field(v, 6) != 4'd0);
        status[`BIT_BORDER]                = (vec_field(v, 7) != 4'd0);
    endtask

    // **************************************************
    // compare and report
    // **************************************************

    task automatic check_typ(input string name, input cart_typ_t got, input cart_typ_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_cfg(input string name, input user_config_t got,
                             input user_config_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic verify_handshakes(input int base, input int expected);
        checks++;
        if (hs_done - base != expected) begin
            errors++;
            $display("%0d reload handshakes completed where %0d were expected",
                     hs_done - base, expected);
        end
    endtask

    task automatic report_test(input string name, input int err_base);
        if (errors == err_base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_base);
        end
    endtask

    // **************************************************
    // tests
    // **************************************************

    task automatic reset_test();
        wait (hs_done == 1);
        repeat (2) @(negedge clk);
        check_bit("reload_req", reload_req, 1'b0);
        check_typ("loaded_a", loaded_a, cart_rom);  // both select codes zero
        check_typ("loaded_b", loaded_b, cart_fdc);
        verify_handshakes(0, 1);
        last_a = cart_rom;
        last_b = cart_fdc;
        report_test("reset", 0);
    endtask

    task automatic vector_test(input int v);
        cart_typ_t exp_a;
        cart_typ_t exp_b;
        logic      changed;
        int        hs_base;
        int        err_base;
        exp_a    = cart_typ_t'(vec_field(v, 8));
        exp_b    = cart_typ_t'(vec_field(v, 9));
        changed  = (exp_a != last_a) || (exp_b != last_b);
        hs_base  = hs_done;
        err_base = errors;
        @(negedge clk);
        apply_vector(v);
        repeat (2) @(negedge clk);  // decoder cycle, then req
        check_typ("cart_a_typ", cart_a_typ, exp_a);
        check_typ("cart_b_typ", cart_b_typ, exp_b);
        check_bit("rom_a_hide", rom_a_hide, exp_a != cart_rom);
        check_bit("rom_b_hide", rom_b_hide, exp_b != cart_rom);
        check_cfg("user_cfg", user_cfg, model_cfg(v));
        check_bit("reload_req", reload_req, changed);
        if (changed) begin
            wait (hs_done == hs_base + 1);
            repeat (2) @(negedge clk);
            check_bit("reload_req", reload_req, 1'b0);  // no second request
            check_typ("loaded_a", loaded_a, exp_a);
            check_typ("loaded_b", loaded_b, exp_b);
        end
        verify_handshakes(hs_base, changed ? 1 : 0);
        last_a = exp_a;
        last_b = exp_b;
        report_test($sformatf("vector %0d", v), err_base);
    endtask

    task automatic burst_test();
        int hs_base;
        int err_base;
        hs_base  = hs_done;
        err_base = errors;
        @(negedge clk);
        apply_vector(1);
        while (!reload_req) begin
            @(negedge clk);
        end
        apply_vector(2);  // two changes inside one handshake
        @(negedge clk);
        apply_vector(3);
        wait (hs_done == hs_base + 2);
        repeat (2) @(negedge clk);
        check_bit("reload_req", reload_req, 1'b0);
        check_typ("loaded_a", loaded_a, cart_typ_t'(vec_field(3, 8)));
        check_typ("loaded_b", loaded_b, cart_typ_t'(vec_field(3, 9)));
        verify_handshakes(hs_base, 2);
        report_test("burst", err_base);
    endtask

    // loader side of the reload handshake
    initial begin
        int delay;
        reload_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (reload_req) begin
                loaded_a  = cart_a_typ;
                loaded_b  = cart_b_typ;
                lcg_state = lcg_next(lcg_state);
                delay     = 1 + int'(lcg_state[17:16]);  // 1 to 4 cycles
                repeat (delay) @(negedge clk);
                reload_ack = 1'b1;
                while (reload_req) begin
                    @(negedge clk);
                end
                reload_ack = 1'b0;
                hs_done++;
            end
        end
    end

    initial begin
        #(NUM_TESTS * 20 * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        status      = '0;
        disable_fdc = 1'b0;
        ocm_mode    = 1'b0;
        $readmemh("testbench/config_input.txt", vec_mem);
        reset_test();
        for (int v = 0; v < NUM_VEC; v++) begin
            vector_test(v);
        end
        burst_test();
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verilog/config_combiner.sv ====
`default_nettype none

module config_combiner
    import msx_cart_pkg::*;
    import msx_user_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         ocm_sw11,
    input  logic         ocm_sw15,
    input  logic         cas_src,
    input  logic         border,
    slot_if.combiner     slot_a,
    slot_if.combiner     slot_b,
    input  logic         reload_ack,
    output logic         reload_req,
    output user_config_t user_cfg,
    output logic         rom_a_hide,
    output logic         rom_b_hide
);

    // **************************************************
    // user config and hide flags
    // **************************************************

    assign user_cfg.cas_audio_src = cas_audio_src_t'(cas_src);
    assign user_cfg.border        = border;
    assign user_cfg.ocm_dip       = {1'b0, ~ocm_sw11, slot_b.ocm_code,
                                     slot_a.is_megaram, 2'b00, ocm_sw15};

    assign rom_a_hide = slot_a.rom_hide;
    assign rom_b_hide = slot_b.rom_hide;

    // **************************************************
    // reload request on change of the type pair
    // **************************************************

    reload_state_t state;
    logic [7:0]    act_config;
    logic [7:0]    last_config;  // pair the loader has acknowledged
    logic [7:0]    snap_config;  // pair sent with the current req

    assign act_config = {slot_b.typ, slot_a.typ};

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= rl_idle;
            reload_req  <= 1'b0;
            last_config <= {cart_empty, cart_empty};
        end else begin
            case (state)
                rl_idle: begin
                    if (act_config != last_config) begin
                        snap_config <= act_config;
                        reload_req  <= 1'b1;
                        state       <= rl_req;
                    end
                end
                rl_req: begin
                    if (reload_ack) begin
                        last_config <= snap_config;
                        reload_req  <= 1'b0;
                        state       <= rl_wait_ack_low;
                    end
                end
                rl_wait_ack_low: begin
                    if (!reload_ack) state <= rl_idle;  // loader done
                end
                default: state <= rl_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/msx_cart_pkg.sv ====
`default_nettype none

package msx_cart_pkg;

    // **************************************************
    // cartridge types as seen by the slot logic
    // **************************************************

    typedef enum logic [3:0] {
        cart_rom,
        cart_scc,
        cart_scc2,           // scc+
        cart_fm_pac,
        cart_megascc1,       // megascc+ 1MB
        cart_megascc2,       // megascc+ 2MB
        cart_mfrsd,          // megaflashrom scc+ sd
        cart_gm2,            // gamemaster2
        cart_fdc,
        cart_mega_ascii8,
        cart_mega_ascii16,
        cart_megaram,        // ocm mode only
        cart_empty
    } cart_typ_t;

    // mapper code handed to the OCM dip byte
    typedef enum logic [1:0] {
        ocm_none    = 2'd0,
        ocm_ascii8  = 2'd1,
        ocm_scc2    = 2'd2,
        ocm_ascii16 = 2'd3
    } ocm_map_t;

endpackage

`default_nettype wire

// ==== verilog/msx_config.sv ====
`default_nettype none
`include "msx_macros.svh"

module msx_config
    import msx_cart_pkg::*;
    import msx_user_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`STATUS_W-1:0] status,
    input  logic                 disable_fdc,
    input  logic                 ocm_mode,
    input  logic                 reload_ack,
    output cart_typ_t            cart_a_typ,
    output cart_typ_t            cart_b_typ,
    output logic                 rom_a_hide,
    output logic                 rom_b_hide,
    output user_config_t         user_cfg,
    output logic                 reload_req
);

    slot_if slot_a ();
    slot_if slot_b ();

    slot_a_decoder u_slot_a (
        .clk      (clk),
        .reset    (reset),
        .sel      (status[`SLOT_A_LSB +: `SLOT_SEL_W]),
        .ocm_mode (ocm_mode),
        .slot     (slot_a.decoder)
    );

    slot_b_decoder u_slot_b (
        .clk         (clk),
        .reset       (reset),
        .sel         (status[`SLOT_B_LSB +: `SLOT_SEL_W]),
        .ocm_mode    (ocm_mode),
        .disable_fdc (disable_fdc),
        .slot        (slot_b.decoder)
    );

    config_combiner u_combiner (
        .clk        (clk),
        .reset      (reset),
        .ocm_sw11   (status[`BIT_OCM_SW11]),
        .ocm_sw15   (status[`BIT_OCM_SW15]),
        .cas_src    (status[`BIT_CAS_SRC]),
        .border     (status[`BIT_BORDER]),
        .slot_a     (slot_a.combiner),
        .slot_b     (slot_b.combiner),
        .reload_ack (reload_ack),
        .reload_req (reload_req),
        .user_cfg   (user_cfg),
        .rom_a_hide (rom_a_hide),
        .rom_b_hide (rom_b_hide)
    );

    assign cart_a_typ = slot_a.typ;
    assign cart_b_typ = slot_b.typ;

endmodule

`default_nettype wire

// ==== verilog/msx_macros.svh ====
`ifndef MSX_MACROS_SVH
`define MSX_MACROS_SVH

// **************************************************
// status word layout, fixed by the menu
// **************************************************

`define STATUS_W      64  // width of the option word

// cartridge slot select fields
`define SLOT_SEL_W    4
`define SLOT_A_LSB    17  // O[20:17] slot 1
`define SLOT_B_LSB    29  // O[32:29] slot 2

// OCM switches
`define BIT_OCM_SW11  11
`define BIT_OCM_SW15  15

// user options
`define BIT_CAS_SRC   40  // cassette audio from adc
`define BIT_BORDER    41

`endif

// ==== verilog/msx_user_pkg.sv ====
`default_nettype none

package msx_user_pkg;

    typedef enum logic {
        cas_file = 1'b0,
        cas_adc  = 1'b1
    } cas_audio_src_t;

    // **************************************************
    // user configuration, 10 bits
    // **************************************************

    typedef struct packed {
        cas_audio_src_t cas_audio_src;
        logic           border;
        logic [7:0]     ocm_dip;  // OCM dip switch byte
    } user_config_t;

    // reload handshake toward the loader
    typedef enum logic [1:0] {
        rl_idle,
        rl_req,          // req high, waiting for ack
        rl_wait_ack_low
    } reload_state_t;

endpackage

`default_nettype wire

// ==== verilog/slot_a_decoder.sv ====
`default_nettype none
`include "msx_macros.svh"

module slot_a_decoder
    import msx_cart_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`SLOT_SEL_W-1:0] sel,
    input  logic                   ocm_mode,
    slot_if.decoder                slot
);

    cart_typ_t typ_d;
    logic      code4;

    assign code4 = (sel == `SLOT_SEL_W'd4);

    always_comb begin
        case (sel)
            `SLOT_SEL_W'd0: typ_d = cart_rom;
            `SLOT_SEL_W'd1: typ_d = cart_scc;
            `SLOT_SEL_W'd2: typ_d = cart_scc2;
            `SLOT_SEL_W'd3: typ_d = cart_fm_pac;
            `SLOT_SEL_W'd4: typ_d = ocm_mode ? cart_megaram : cart_megascc1;
            `SLOT_SEL_W'd5: typ_d = cart_mfrsd;
            `SLOT_SEL_W'd6: typ_d = cart_gm2;
            default:        typ_d = cart_empty;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            slot.typ        <= cart_empty;
            slot.ocm_code   <= ocm_none;
            slot.rom_hide   <= 1'b1;
            slot.is_megaram <= 1'b0;
        end else begin
            slot.typ        <= typ_d;
            slot.ocm_code   <= code4 ? ocm_ascii8 : ocm_none;
            slot.rom_hide   <= (typ_d != cart_rom);
            slot.is_megaram <= code4;      // ocm slot 1 flag, any mode
        end
    end

endmodule

`default_nettype wire

// ==== verilog/slot_b_decoder.sv ====
`default_nettype none
`include "msx_macros.svh"

module slot_b_decoder
    import msx_cart_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`SLOT_SEL_W-1:0] sel,
    input  logic                   ocm_mode,
    input  logic                   disable_fdc,
    slot_if.decoder                slot
);

    cart_typ_t typ_d;
    ocm_map_t  ocm_d;

    always_comb begin
        case (sel)
            `SLOT_SEL_W'd0: typ_d = disable_fdc ? cart_empty : cart_fdc;
            `SLOT_SEL_W'd1: typ_d = cart_rom;
            `SLOT_SEL_W'd2: typ_d = cart_scc;
            `SLOT_SEL_W'd3: typ_d = cart_scc2;
            `SLOT_SEL_W'd4: typ_d = cart_fm_pac;
            `SLOT_SEL_W'd5: typ_d = ocm_mode ? cart_megaram : cart_megascc2;
            `SLOT_SEL_W'd6: typ_d = ocm_mode ? cart_megaram : cart_mega_ascii8;
            `SLOT_SEL_W'd7: typ_d = ocm_mode ? cart_megaram : cart_mega_ascii16;
            default:        typ_d = cart_empty;
        endcase
    end

    // mapper code follows the menu entry, not the mode
    always_comb begin
        case (sel)
            `SLOT_SEL_W'd5: ocm_d = ocm_scc2;
            `SLOT_SEL_W'd6: ocm_d = ocm_ascii8;
            `SLOT_SEL_W'd7: ocm_d = ocm_ascii16;
            default:        ocm_d = ocm_none;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            slot.typ        <= cart_empty;
            slot.ocm_code   <= ocm_none;
            slot.rom_hide   <= 1'b1;
            slot.is_megaram <= 1'b0;
        end else begin
            slot.typ        <= typ_d;
            slot.ocm_code   <= ocm_d;
            slot.rom_hide   <= (typ_d != cart_rom);
            slot.is_megaram <= (ocm_d != ocm_none);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/slot_if.sv ====
`default_nettype none

interface slot_if
    import msx_cart_pkg::*;
();

    cart_typ_t typ;
    ocm_map_t  ocm_code;
    logic      rom_hide;    // loader hides the rom entry
    logic      is_megaram;

    modport decoder (
        output typ,
        output ocm_code,
        output rom_hide,
        output is_megaram
    );

    modport combiner (
        input typ,
        input ocm_code,
        input rom_hide,
        input is_megaram
    );

endinterface

`default_nettype wire
